// File: hw/rrat_pkg.sv
package rrat_pkg;

    // Core sizes.
    localparam int retire_width = 2;
    localparam int arch_regs    = 32;
    localparam int phys_regs    = 64;
    localparam int free_regs    = phys_regs - arch_regs;

    localparam int arn_bits  = $clog2(arch_regs);
    localparam int prn_bits  = $clog2(phys_regs);
    localparam int ptr_bits  = $clog2(free_regs);
    localparam int word_bits = arn_bits + prn_bits;

    typedef logic [arn_bits-1:0] arn_t;
    typedef logic [prn_bits-1:0] prn_t;
    typedef logic [ptr_bits-1:0] free_ptr_t;

    // Register writer view of a retiring lane.
    typedef struct packed {
        arn_t arn;
        prn_t prn;
    } retire_reg_t;

    // Branch view of the same word.
    typedef struct packed {
        logic                 mispredict;
        logic [word_bits-2:0] reserved;
    } retire_ctl_t;

    // The lane's kind bit picks which view applies.
    typedef union packed {
        retire_reg_t regs;
        retire_ctl_t ctl;
    } retire_payload_t;

endpackage

// File: hw/rrat_map.sv
`timescale 1ns/1ps

module rrat_map (
    input  logic                                              clock,
    input  logic                                              reset,
    input  logic [rrat_pkg::retire_width-1:0]                 retire_valid,
    input  logic [rrat_pkg::retire_width-1:0]                 retire_ctl,
    input  rrat_pkg::retire_payload_t [rrat_pkg::retire_width-1:0] retire_payload,
    output logic [rrat_pkg::retire_width-1:0]                 release_valid,
    output rrat_pkg::prn_t [rrat_pkg::retire_width-1:0]       release_prn,
    output rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0]          map_entries,
    output logic                                              squash
);

    rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0] map_q;
    rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0] map_next;
    logic                                     squash_q;
    logic                                     squash_next;
    logic                                     committing;   // Cleared by a gap or a mispredict.
    rrat_pkg::retire_reg_t                    lane_reg;
    rrat_pkg::retire_ctl_t                    lane_ctl;

    always_comb begin
        map_next      = map_q;
        squash_next   = 1'b0;
        release_valid = '0;
        release_prn   = '0;
        committing    = ~squash_q;   // ROB is flushing during the squash cycle.

        for (int i = 0; i < rrat_pkg::retire_width; i++) begin
            lane_reg = retire_payload[i].regs;
            lane_ctl = retire_payload[i].ctl;

            if (committing && retire_valid[i]) begin
                if (retire_ctl[i]) begin
                    // Younger lanes are on the wrong path.
                    if (lane_ctl.mispredict) begin
                        squash_next = 1'b1;
                        committing  = 1'b0;
                    end
                end else if (lane_reg.arn != '0) begin
                    // Read the working copy so a same-arn lane frees the earlier lane's prn.
                    release_valid[i]       = 1'b1;
                    release_prn[i]         = map_next[lane_reg.arn];
                    map_next[lane_reg.arn] = lane_reg.prn;
                end
            end else begin
                committing = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            squash_q <= 1'b0;
            for (int i = 0; i < rrat_pkg::arch_regs; i++) begin
                map_q[i] <= rrat_pkg::prn_t'(i);   // Identity mapping.
            end
        end else begin
            squash_q <= squash_next;
            map_q    <= map_next;
        end
    end

    assign map_entries = map_q;
    assign squash      = squash_q;

endmodule

// File: hw/rrat_free_list.sv
`timescale 1ns/1ps

module rrat_free_list (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic [rrat_pkg::retire_width-1:0]           release_valid,
    input  rrat_pkg::prn_t [rrat_pkg::retire_width-1:0] release_prn,
    output rrat_pkg::prn_t [rrat_pkg::free_regs-1:0]    free_entries,
    output rrat_pkg::free_ptr_t                         free_head
);

    rrat_pkg::prn_t [rrat_pkg::free_regs-1:0] ring_q;
    rrat_pkg::prn_t [rrat_pkg::free_regs-1:0] ring_next;
    rrat_pkg::free_ptr_t                      head_q;
    rrat_pkg::free_ptr_t                      head_next;

    // Steps a ring index and wraps at the last entry.
    function automatic rrat_pkg::free_ptr_t ring_step(input rrat_pkg::free_ptr_t ptr);
        if (ptr == rrat_pkg::free_ptr_t'(rrat_pkg::free_regs - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Each retire pops the head entry and pushes the released prn into
    // that same slot, so only the head pointer moves.
    always_comb begin
        ring_next = ring_q;
        head_next = head_q;

        for (int i = 0; i < rrat_pkg::retire_width; i++) begin
            if (release_valid[i]) begin
                ring_next[head_next] = release_prn[i];
                head_next            = ring_step(head_next);   // Idle lanes leave no gap.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q <= '0;
            for (int j = 0; j < rrat_pkg::free_regs; j++) begin
                ring_q[j] <= rrat_pkg::prn_t'(rrat_pkg::arch_regs + j);
            end
        end else begin
            head_q <= head_next;
            ring_q <= ring_next;
        end
    end

    assign free_entries = ring_q;
    assign free_head    = head_q;

endmodule

// File: hw/recovery_bundler.sv
`timescale 1ns/1ps

module recovery_bundler (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     squash,
    input  rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0] map_entries,
    input  rrat_pkg::prn_t [rrat_pkg::free_regs-1:0] free_entries,
    input  rrat_pkg::free_ptr_t                      free_head,
    output logic                                     recover_valid,
    output rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0] recover_map,
    output rrat_pkg::prn_t [rrat_pkg::free_regs-1:0] recover_free,
    output rrat_pkg::free_ptr_t                      recover_head,
    output logic [rrat_pkg::phys_regs-1:0]           recover_in_use
);

    logic [rrat_pkg::phys_regs-1:0] in_use;

    // Every prn named by the committed map is live.
    // The front end frees the rest when it rebuilds its list.
    always_comb begin
        in_use = '0;
        for (int i = 0; i < rrat_pkg::arch_regs; i++) begin
            in_use[map_entries[i]] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            recover_valid  <= 1'b0;
            recover_map    <= '0;
            recover_free   <= '0;
            recover_head   <= '0;
            recover_in_use <= '0;
        end else begin
            recover_valid <= squash;   // One cycle pulse per squash.
            if (squash) begin
                recover_map    <= map_entries;
                recover_free   <= free_entries;
                recover_head   <= free_head;
                recover_in_use <= in_use;
            end
        end
    end

endmodule

// File: hw/retire_unit.sv
`timescale 1ns/1ps

module retire_unit (
    input  logic                                              clock,
    input  logic                                              reset,
    input  logic [rrat_pkg::retire_width-1:0]                 retire_valid,
    input  logic [rrat_pkg::retire_width-1:0]                 retire_ctl,
    input  rrat_pkg::retire_payload_t [rrat_pkg::retire_width-1:0] retire_payload,
    output rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0]          map_entries,
    output rrat_pkg::prn_t [rrat_pkg::free_regs-1:0]          free_entries,
    output rrat_pkg::free_ptr_t                               free_head,
    output logic                                              squash,
    output logic                                              recover_valid,
    output rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0]          recover_map,
    output rrat_pkg::prn_t [rrat_pkg::free_regs-1:0]          recover_free,
    output rrat_pkg::free_ptr_t                               recover_head,
    output logic [rrat_pkg::phys_regs-1:0]                    recover_in_use
);

    logic [rrat_pkg::retire_width-1:0]           release_valid;
    rrat_pkg::prn_t [rrat_pkg::retire_width-1:0] release_prn;   // Old mappings going back.

    rrat_map u_map (
        .clock          (clock),
        .reset          (reset),
        .retire_valid   (retire_valid),
        .retire_ctl     (retire_ctl),
        .retire_payload (retire_payload),
        .release_valid  (release_valid),
        .release_prn    (release_prn),
        .map_entries    (map_entries),
        .squash         (squash)
    );

    rrat_free_list u_free_list (
        .clock         (clock),
        .reset         (reset),
        .release_valid (release_valid),
        .release_prn   (release_prn),
        .free_entries  (free_entries),
        .free_head     (free_head)
    );

    // Samples both states in the squash cycle.
    recovery_bundler u_bundler (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .map_entries    (map_entries),
        .free_entries   (free_entries),
        .free_head      (free_head),
        .recover_valid  (recover_valid),
        .recover_map    (recover_map),
        .recover_free   (recover_free),
        .recover_head   (recover_head),
        .recover_in_use (recover_in_use)
    );

endmodule

// File: verification/retire_model.svh
`ifndef RETIRE_MODEL_SVH
`define RETIRE_MODEL_SVH

// Committed state as the reorder buffer retires into it.
rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0] model_map;
rrat_pkg::prn_t [rrat_pkg::free_regs-1:0] model_ring;
rrat_pkg::free_ptr_t                      model_head;
logic [31:0]                              lfsr_state = 32'hcfae;

// Fibonacci LFSR with taps 32 22 2 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < count; k++) begin
        lfsr_state = lfsr_step(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};   // One step per bit.
    end
    return bits;
endfunction

function automatic void model_reset();
    for (int i = 0; i < rrat_pkg::arch_regs; i++) begin
        model_map[i] = rrat_pkg::prn_t'(i);
    end
    for (int j = 0; j < rrat_pkg::free_regs; j++) begin
        model_ring[j] = rrat_pkg::prn_t'(rrat_pkg::arch_regs + j);
    end
    model_head = '0;
endfunction

// The head slot was consumed by the retiring writer, so the old prn lands there.
function automatic void free_push(input rrat_pkg::prn_t prn);
    model_ring[model_head] = prn;
    model_head = rrat_pkg::free_ptr_t'((int'(model_head) + 1) % rrat_pkg::free_regs);
endfunction

// Commits one cycle of lanes and returns 1 when a mispredict schedules a squash.
function automatic logic apply_retire(
    input logic [rrat_pkg::retire_width-1:0]                  valid,
    input logic [rrat_pkg::retire_width-1:0]                  ctl,
    input rrat_pkg::retire_payload_t [rrat_pkg::retire_width-1:0] payload
);
    rrat_pkg::arn_t arn;
    for (int i = 0; i < rrat_pkg::retire_width; i++) begin
        if (!valid[i]) begin
            return 1'b0;   // A gap drops every younger lane.
        end
        if (ctl[i]) begin
            if (payload[i].ctl.mispredict) begin
                return 1'b1;
            end
        end else begin
            arn = payload[i].regs.arn;
            if (arn != '0) begin
                free_push(model_map[arn]);
                model_map[arn] = payload[i].regs.prn;
            end
        end
    end
    return 1'b0;
endfunction

function automatic logic [rrat_pkg::phys_regs-1:0] in_use_of(
    input rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0] map
);
    logic [rrat_pkg::phys_regs-1:0] bits;
    bits = '0;
    for (int i = 0; i < rrat_pkg::arch_regs; i++) begin
        bits[map[i]] = 1'b1;
    end
    return bits;
endfunction

`endif

// File: verification/retire_unit_tb.sv
`timescale 1ns/1ps

module retire_unit_tb;

    typedef logic [rrat_pkg::arch_regs*rrat_pkg::prn_bits-1:0] word_t;

    logic                                                   clock = 1'b0;
    logic                                                   reset;
    logic [rrat_pkg::retire_width-1:0]                      retire_valid;
    logic [rrat_pkg::retire_width-1:0]                      retire_ctl;
    rrat_pkg::retire_payload_t [rrat_pkg::retire_width-1:0] retire_payload;
    rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0]               map_entries;
    rrat_pkg::prn_t [rrat_pkg::free_regs-1:0]               free_entries;
    rrat_pkg::free_ptr_t                                    free_head;
    logic                                                   squash;
    logic                                                   recover_valid;
    rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0]               recover_map;
    rrat_pkg::prn_t [rrat_pkg::free_regs-1:0]               recover_free;
    rrat_pkg::free_ptr_t                                    recover_head;
    logic [rrat_pkg::phys_regs-1:0]                         recover_in_use;

    // Expected squash and recovery bundle.
    logic                                     exp_squash;
    logic                                     exp_recover_valid;
    rrat_pkg::prn_t [rrat_pkg::arch_regs-1:0] exp_recover_map;
    rrat_pkg::prn_t [rrat_pkg::free_regs-1:0] exp_recover_free;
    rrat_pkg::free_ptr_t                      exp_recover_head;
    logic [rrat_pkg::phys_regs-1:0]           exp_recover_in_use;

    string test_name = "reset_state";
    int    error_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 1000000;
    int    random_len = 500;

    `include "retire_model.svh"

    retire_unit u_retire_unit (.*);

    always #5 clock = ~clock;

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Error %s: %s expected %h actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_outputs();
        check_value("map_entries", word_t'(model_map), word_t'(map_entries));
        check_value("free_entries", word_t'(model_ring), word_t'(free_entries));
        check_value("free_head", word_t'(model_head), word_t'(free_head));
        check_value("squash", word_t'(exp_squash), word_t'(squash));
        check_value("recover_valid", word_t'(exp_recover_valid), word_t'(recover_valid));
        check_value("recover_map", word_t'(exp_recover_map), word_t'(recover_map));
        check_value("recover_free", word_t'(exp_recover_free), word_t'(recover_free));
        check_value("recover_head", word_t'(exp_recover_head), word_t'(recover_head));
        check_value("recover_in_use", word_t'(exp_recover_in_use), word_t'(recover_in_use));
    endtask

    // The model takes the lanes sampled at this edge, then the outputs are compared.
    always @(posedge clock) begin
        if (reset) begin
            model_reset();
            exp_squash         = 1'b0;
            exp_recover_valid  = 1'b0;
            exp_recover_map    = '0;
            exp_recover_free   = '0;
            exp_recover_head   = '0;
            exp_recover_in_use = '0;
        end else begin
            exp_recover_valid = exp_squash;
            if (exp_squash) begin
                exp_recover_map    = model_map;
                exp_recover_free   = model_ring;
                exp_recover_head   = model_head;
                exp_recover_in_use = in_use_of(model_map);
                exp_squash         = 1'b0;   // The ROB flushes this cycle.
            end else begin
                exp_squash = apply_retire(retire_valid, retire_ctl, retire_payload);
            end
        end
        #1;
        if (!reset) begin
            compare_outputs();
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic rrat_pkg::retire_payload_t reg_word(input int arn, input int prn);
        rrat_pkg::retire_payload_t word;
        word.regs.arn = rrat_pkg::arn_t'(arn);
        word.regs.prn = rrat_pkg::prn_t'(prn);
        return word;
    endfunction

    function automatic rrat_pkg::retire_payload_t ctl_word(input int mispredict);
        rrat_pkg::retire_payload_t word;
        word = '0;
        word.ctl.mispredict = (mispredict != 0);
        return word;
    endfunction

    task automatic drive_cycle(input logic [rrat_pkg::retire_width-1:0] valid,
                               input logic [rrat_pkg::retire_width-1:0] ctl,
                               input rrat_pkg::retire_payload_t word0,
                               input rrat_pkg::retire_payload_t word1);
        @(negedge clock);
        retire_valid      = valid;
        retire_ctl        = ctl;
        retire_payload[0] = word0;
        retire_payload[1] = word1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle(2'b00, 2'b00, '0, '0);
    endtask

    initial begin
        int errors_before;
        int tests_run;
        int tests_failed;
        logic [rrat_pkg::retire_width-1:0] lane_valid;
        logic [rrat_pkg::retire_width-1:0] lane_ctl;
        rrat_pkg::retire_payload_t [rrat_pkg::retire_width-1:0] lane_word;

        cycle_limit    = (200 + random_len) * 3 / 2;   // Directed allowance plus the random stream.
        tests_run      = 0;
        tests_failed   = 0;
        reset          = 1'b1;
        retire_valid   = '0;
        retire_ctl     = '0;
        retire_payload = '0;
        repeat (2) @(negedge clock);
        reset = 1'b0;

        for (int t = 0; t < 5; t++) begin
            errors_before = error_count;
            case (t)
                0: test_name = "reset_state";
                1: test_name = "register_retire";
                2: test_name = "in_order_stop";
                3: test_name = "mispredict";
                default: test_name = "random_stream";
            endcase
            if (t == 1) begin
                drive_cycle(2'b01, 2'b00, reg_word(3, 40), '0);
                drive_cycle(2'b11, 2'b00, reg_word(4, 41), reg_word(5, 42));
                drive_cycle(2'b11, 2'b00, reg_word(7, 43), reg_word(7, 44));
                drive_cycle(2'b11, 2'b00, reg_word(0, 45), reg_word(0, 46));
            end else if (t == 2) begin
                drive_cycle(2'b10, 2'b00, reg_word(9, 47), reg_word(9, 50));
                drive_cycle(2'b11, 2'b01, ctl_word(0), reg_word(9, 51));
            end else if (t == 3) begin
                drive_cycle(2'b11, 2'b01, ctl_word(1), reg_word(10, 52));
                drive_cycle(2'b11, 2'b00, reg_word(11, 53), reg_word(12, 54));
            end else if (t == 4) begin
                for (int n = 0; n < random_len; n++) begin
                    for (int i = 0; i < rrat_pkg::retire_width; i++) begin
                        lane_valid[i] = (take_bits(2) != 0);
                        lane_ctl[i]   = (take_bits(3) == 0);
                        if (lane_ctl[i]) begin
                            lane_word[i] = ctl_word(int'(take_bits(1)));
                        end else begin
                            lane_word[i] = reg_word(int'(take_bits(5)), int'(take_bits(6)));
                        end
                    end
                    drive_cycle(lane_valid, lane_ctl, lane_word[0], lane_word[1]);
                end
            end
            idle(3);   // Lets squash and recovery from the last lanes drain.
            tests_run++;
            if (error_count != errors_before) begin
                tests_failed++;
            end
            $display("Test %s finished with %0d errors", test_name, error_count - errors_before);
        end

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
hw/rrat_pkg.sv
hw/rrat_map.sv
hw/rrat_free_list.sv
hw/recovery_bundler.sv
hw/retire_unit.sv
verification/retire_unit_tb.sv

// File: run.sh
#!/bin/sh
# Builds the retire unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module retire_unit_tb -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vretire_unit_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
